/* common/ctrl_if.sv */
interface ctrl_if;

    decode_pkg::op_class_e op_class;
    decode_pkg::alu_op_e   alu_op;
    decode_pkg::imm_kind_e imm_kind;
    decode_pkg::mem_size_e mem_size;
    logic                  mem_unsigned;
    logic                  illegal;

    modport producer (
        output op_class, alu_op, imm_kind, mem_size, mem_unsigned, illegal
    );

    modport consumer (
        input op_class, alu_op, imm_kind, mem_size, mem_unsigned, illegal
    );

endinterface

/* common/decode_pkg.sv */
package decode_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // the six base formats, all views of one 32-bit word
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_t;

    typedef enum logic [3:0] {
        op_alu_reg, op_alu_imm, op_lui, op_auipc, op_jal,
        op_jalr, op_branch, op_load, op_store, op_illegal
    } op_class_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
    } imm_kind_e;

    // encoding matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        mem_byte, mem_half, mem_word, mem_double
    } mem_size_e;

    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] f7_normal = 7'b0000000;
    localparam logic [6:0] f7_alt    = 7'b0100000; // sub, sra

endpackage

/* logic/branch_unit.sv */
module branch_unit (
    ctrl_if.consumer          ctrl,
    input  logic [2:0]        funct3,
    input  decode_pkg::word_t pc,
    input  decode_pkg::word_t rs1_data,
    input  decode_pkg::word_t rs2_data,
    input  decode_pkg::word_t imm,
    output logic              taken,
    output decode_pkg::word_t target
);

    logic              eq;
    logic              lt;
    logic              ltu;
    logic              cond;
    decode_pkg::word_t jalr_sum;

    assign eq       = rs1_data == rs2_data;
    assign lt       = $signed(rs1_data) < $signed(rs2_data);
    assign ltu      = rs1_data < rs2_data;
    assign jalr_sum = rs1_data + imm;

    always_comb begin
        case (funct3)
            decode_pkg::f3_beq:  cond = eq;
            decode_pkg::f3_bne:  cond = !eq;
            decode_pkg::f3_blt:  cond = lt;
            decode_pkg::f3_bge:  cond = !lt;
            decode_pkg::f3_bltu: cond = ltu;
            decode_pkg::f3_bgeu: cond = !ltu;
            default:             cond = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.op_class)
            decode_pkg::op_branch: begin
                taken  = cond;
                target = pc + imm;
            end
            decode_pkg::op_jal: begin
                taken  = 1'b1;
                target = pc + imm;
            end
            decode_pkg::op_jalr: begin
                taken  = 1'b1;
                target = {jalr_sum[decode_pkg::xlen-1:1], 1'b0}; // lsb cleared
            end
            default: begin
                taken  = 1'b0;
                target = '0;
            end
        endcase
    end

endmodule

/* logic/decode_stage.sv */
module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  decode_pkg::word_t     in_pc,
    input  logic [31:0]           in_instr,
    output decode_pkg::reg_addr_t rs1_addr,
    output decode_pkg::reg_addr_t rs2_addr,
    input  decode_pkg::word_t     rs1_data,
    input  decode_pkg::word_t     rs2_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output decode_pkg::word_t     out_pc,
    output decode_pkg::word_t     out_srca,
    output decode_pkg::word_t     out_srcb,
    output decode_pkg::word_t     out_imm,
    output decode_pkg::word_t     out_target,
    output decode_pkg::reg_addr_t out_rd,
    output decode_pkg::op_class_e out_op_class,
    output decode_pkg::alu_op_e   out_alu_op,
    output decode_pkg::mem_size_e out_mem_size,
    output logic                  out_mem_unsigned,
    output logic                  out_taken,
    output logic                  out_illegal
);

    decode_pkg::instr_t instr;
    decode_pkg::word_t  imm;
    decode_pkg::word_t  target;
    logic               taken;

    ctrl_if ctrl ();

    assign instr    = in_instr;
    assign rs1_addr = instr.r.rs1; // regfile read is combinational
    assign rs2_addr = instr.r.rs2;

    opcode_decoder i_opcode_decoder (
        .instr (instr),
        .ctrl  (ctrl.producer)
    );

    imm_gen i_imm_gen (
        .instr (instr),
        .ctrl  (ctrl.consumer),
        .imm   (imm)
    );

    branch_unit i_branch_unit (
        .ctrl     (ctrl.consumer),
        .funct3   (instr.r.funct3),
        .pc       (in_pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .taken    (taken),
        .target   (target)
    );

    operand_stage i_operand_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .ctrl             (ctrl.consumer),
        .instr            (instr),
        .pc               (in_pc),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .imm              (imm),
        .target           (target),
        .taken            (taken),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_pc           (out_pc),
        .out_srca         (out_srca),
        .out_srcb         (out_srcb),
        .out_imm          (out_imm),
        .out_target       (out_target),
        .out_rd           (out_rd),
        .out_op_class     (out_op_class),
        .out_alu_op       (out_alu_op),
        .out_mem_size     (out_mem_size),
        .out_mem_unsigned (out_mem_unsigned),
        .out_taken        (out_taken),
        .out_illegal      (out_illegal)
    );

endmodule

/* logic/imm_gen.sv */
module imm_gen (
    input  decode_pkg::instr_t instr,
    ctrl_if.consumer           ctrl,
    output decode_pkg::word_t  imm
);

    localparam int xlen = decode_pkg::xlen;

    always_comb begin
        case (ctrl.imm_kind)
            decode_pkg::imm_i: begin
                imm = {{(xlen-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            decode_pkg::imm_s: begin
                imm = {{(xlen-12){instr.s.imm_11_5[6]}},
                       instr.s.imm_11_5, instr.s.imm_4_0};
            end
            decode_pkg::imm_b: begin // bit 0 always zero
                imm = {{(xlen-12){instr.b.imm_12}},
                       instr.b.imm_11, instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            decode_pkg::imm_u: begin
                imm = {{(xlen-32){instr.u.imm_31_12[19]}}, instr.u.imm_31_12, 12'h000};
            end
            decode_pkg::imm_j: begin
                imm = {{(xlen-20){instr.j.imm_20}},
                       instr.j.imm_19_12, instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

/* logic/opcode_decoder.sv */
module opcode_decoder (
    input  decode_pkg::instr_t instr,
    ctrl_if.producer           ctrl
);

    logic [6:0]            f7;
    logic                  is_op;
    logic                  norm;
    logic                  alt;
    logic                  bad;
    decode_pkg::op_class_e op_class;
    decode_pkg::alu_op_e   alu_op;
    decode_pkg::imm_kind_e imm_kind;
    decode_pkg::mem_size_e mem_size;
    logic                  mem_unsigned;

    assign f7    = instr.r.funct7;
    assign is_op = instr.r.opcode == decode_pkg::opc_op;

    // op-imm shifts keep bit 25 as the sixth shamt bit
    assign norm = is_op ? f7 == decode_pkg::f7_normal
                        : f7[6:1] == decode_pkg::f7_normal[6:1];
    assign alt  = is_op ? f7 == decode_pkg::f7_alt
                        : f7[6:1] == decode_pkg::f7_alt[6:1];

    always_comb begin
        op_class     = decode_pkg::op_alu_imm;
        alu_op       = decode_pkg::alu_add;
        imm_kind     = decode_pkg::imm_none;
        mem_size     = decode_pkg::mem_double;
        mem_unsigned = 1'b0;
        bad          = 1'b0;
        case (instr.r.opcode)
            decode_pkg::opc_op_imm, decode_pkg::opc_op: begin
                op_class = is_op ? decode_pkg::op_alu_reg : decode_pkg::op_alu_imm;
                imm_kind = is_op ? decode_pkg::imm_none : decode_pkg::imm_i;
                case (instr.r.funct3)
                    decode_pkg::f3_add_sub: begin
                        if (!is_op || norm) begin
                            alu_op = decode_pkg::alu_add;
                        end else if (alt) begin
                            alu_op = decode_pkg::alu_sub;
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    decode_pkg::f3_sll: begin
                        alu_op = decode_pkg::alu_sll;
                        bad    = !norm;
                    end
                    decode_pkg::f3_srl_sra: begin
                        if (norm) begin
                            alu_op = decode_pkg::alu_srl;
                        end else if (alt) begin
                            alu_op = decode_pkg::alu_sra;
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    decode_pkg::f3_slt:  alu_op = decode_pkg::alu_slt;
                    decode_pkg::f3_sltu: alu_op = decode_pkg::alu_sltu;
                    decode_pkg::f3_xor:  alu_op = decode_pkg::alu_xor;
                    decode_pkg::f3_or:   alu_op = decode_pkg::alu_or;
                    default:             alu_op = decode_pkg::alu_and;
                endcase
                // funct7 of register forms is only free for add/sub and shifts
                if (is_op && !norm && instr.r.funct3 != decode_pkg::f3_add_sub
                        && instr.r.funct3 != decode_pkg::f3_srl_sra) begin
                    bad = 1'b1;
                end
            end
            decode_pkg::opc_lui: begin
                op_class = decode_pkg::op_lui;
                imm_kind = decode_pkg::imm_u;
            end
            decode_pkg::opc_auipc: begin
                op_class = decode_pkg::op_auipc;
                imm_kind = decode_pkg::imm_u;
            end
            decode_pkg::opc_jal: begin
                op_class = decode_pkg::op_jal;
                imm_kind = decode_pkg::imm_j;
            end
            decode_pkg::opc_jalr: begin
                op_class = decode_pkg::op_jalr;
                imm_kind = decode_pkg::imm_i;
                bad      = instr.r.funct3 != 3'b000;
            end
            decode_pkg::opc_branch: begin
                op_class = decode_pkg::op_branch;
                imm_kind = decode_pkg::imm_b;
                bad      = instr.r.funct3[2:1] == 2'b01; // funct3 2 and 3 unused
            end
            decode_pkg::opc_load: begin
                op_class     = decode_pkg::op_load;
                imm_kind     = decode_pkg::imm_i;
                mem_size     = decode_pkg::mem_size_e'(instr.r.funct3[1:0]);
                mem_unsigned = instr.r.funct3[2];
                bad          = instr.r.funct3 == 3'b111; // no unsigned double
            end
            decode_pkg::opc_store: begin
                op_class = decode_pkg::op_store;
                imm_kind = decode_pkg::imm_s;
                mem_size = decode_pkg::mem_size_e'(instr.r.funct3[1:0]);
                bad      = instr.r.funct3[2];
            end
            default: bad = 1'b1;
        endcase
    end

    assign ctrl.op_class     = bad ? decode_pkg::op_illegal : op_class;
    assign ctrl.alu_op       = bad ? decode_pkg::alu_add : alu_op;
    assign ctrl.imm_kind     = bad ? decode_pkg::imm_none : imm_kind;
    assign ctrl.mem_size     = bad ? decode_pkg::mem_double : mem_size;
    assign ctrl.mem_unsigned = mem_unsigned & ~bad;
    assign ctrl.illegal      = bad;

endmodule

/* logic/operand_stage.sv */
module operand_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    ctrl_if.consumer              ctrl,
    input  decode_pkg::instr_t    instr,
    input  decode_pkg::word_t     pc,
    input  decode_pkg::word_t     rs1_data,
    input  decode_pkg::word_t     rs2_data,
    input  decode_pkg::word_t     imm,
    input  decode_pkg::word_t     target,
    input  logic                  taken,
    output logic                  out_valid,
    input  logic                  out_ready,
    output decode_pkg::word_t     out_pc,
    output decode_pkg::word_t     out_srca,
    output decode_pkg::word_t     out_srcb,
    output decode_pkg::word_t     out_imm,
    output decode_pkg::word_t     out_target,
    output decode_pkg::reg_addr_t out_rd,
    output decode_pkg::op_class_e out_op_class,
    output decode_pkg::alu_op_e   out_alu_op,
    output decode_pkg::mem_size_e out_mem_size,
    output logic                  out_mem_unsigned,
    output logic                  out_taken,
    output logic                  out_illegal
);

    decode_pkg::word_t srca;
    decode_pkg::word_t srcb;
    logic              accept;

    always_comb begin
        srca = rs1_data;
        srcb = rs2_data;
        case (ctrl.op_class)
            decode_pkg::op_jal, decode_pkg::op_jalr: srcb = pc + 4; // link value
            decode_pkg::op_auipc: begin
                srca = pc;
                srcb = imm;
            end
            decode_pkg::op_lui: begin
                srca = '0;
                srcb = imm;
            end
            decode_pkg::op_alu_imm, decode_pkg::op_load, decode_pkg::op_store: srcb = imm;
            default: ;
        endcase
    end

    // free slot, or the held result leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_pc           <= '0;
            out_srca         <= '0;
            out_srcb         <= '0;
            out_imm          <= '0;
            out_target       <= '0;
            out_rd           <= '0;
            out_op_class     <= decode_pkg::op_alu_reg;
            out_alu_op       <= decode_pkg::alu_add;
            out_mem_size     <= decode_pkg::mem_byte;
            out_mem_unsigned <= 1'b0;
            out_taken        <= 1'b0;
            out_illegal      <= 1'b0;
        end else if (accept) begin
            out_pc           <= pc;
            out_srca         <= srca;
            out_srcb         <= srcb;
            out_imm          <= imm;
            out_target       <= target;
            out_rd           <= instr.r.rd;
            out_op_class     <= ctrl.op_class;
            out_alu_op       <= ctrl.alu_op;
            out_mem_size     <= ctrl.mem_size;
            out_mem_unsigned <= ctrl.mem_unsigned;
            out_taken        <= taken;
            out_illegal      <= ctrl.illegal;
        end
    end

endmodule

/* verif/decode_stage_tb.sv */
module decode_stage_tb;

    localparam int n_vec        = 22;
    localparam int n_field      = 15; // values per vector in the data file
    localparam int clk_period   = 8;
    localparam int reset_cycles = 10;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic                  in_ready;
    decode_pkg::word_t     in_pc;
    logic [31:0]           in_instr;
    decode_pkg::reg_addr_t rs1_addr;
    decode_pkg::reg_addr_t rs2_addr;
    decode_pkg::word_t     rs1_data;
    decode_pkg::word_t     rs2_data;
    logic                  out_valid;
    logic                  out_ready;
    decode_pkg::word_t     out_pc;
    decode_pkg::word_t     out_srca;
    decode_pkg::word_t     out_srcb;
    decode_pkg::word_t     out_imm;
    decode_pkg::word_t     out_target;
    decode_pkg::reg_addr_t out_rd;
    decode_pkg::op_class_e out_op_class;
    decode_pkg::alu_op_e   out_alu_op;
    decode_pkg::mem_size_e out_mem_size;
    logic                  out_mem_unsigned;
    logic                  out_taken;
    logic                  out_illegal;

    logic [63:0]  tdata [0:n_vec*n_field-1];
    int           exp_q [$]; // vector indices in flight
    int           n_checked;
    int           n_accepted;
    int           last_idx;
    logic         accepted_prev;
    logic         was_stalled;
    logic [337:0] out_bundle;
    logic [337:0] held_bundle;
    logic [31:0]  lfsr_state;

    decode_stage i_decode_stage (.*);

    assign out_bundle = {out_pc, out_srca, out_srcb, out_imm, out_target, out_rd,
                         out_op_class, out_alu_op, out_mem_size, out_mem_unsigned,
                         out_taken, out_illegal};

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected %h got %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "run stopped at first error");
        end
    endtask

    task automatic check_result(input int idx);
        int b;
        b = idx * n_field;
        check_value("out_pc", tdata[b], out_pc);
        check_value("out_srca", tdata[b+4], out_srca);
        check_value("out_srcb", tdata[b+5], out_srcb);
        check_value("out_imm", tdata[b+6], out_imm);
        check_value("out_op_class", tdata[b+7], out_op_class);
        if (tdata[b+7] != decode_pkg::op_branch) begin // alu_op free for branches
            check_value("out_alu_op", tdata[b+8], out_alu_op);
        end
        check_value("out_mem_size", tdata[b+9], out_mem_size);
        check_value("out_mem_unsigned", tdata[b+10], out_mem_unsigned);
        check_value("out_taken", tdata[b+11], out_taken);
        check_value("out_target", tdata[b+12], out_target);
        check_value("out_illegal", tdata[b+13], out_illegal);
        check_value("out_rd", tdata[b+14], out_rd);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    initial begin : watchdog
        #((n_vec * 20 + reset_cycles) * clk_period);
        $display("outputs stopped arriving, %0d of %0d vectors checked", n_checked, n_vec);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

    always @(posedge clk) begin : monitor
        int idx;
        if (!rst_n) begin
            check_value("out_valid", 1'b0, out_valid);
            check_value("in_ready", 1'b1, in_ready);
            check_value("out_pc", '0, out_pc);
            check_value("out_srca", '0, out_srca);
            check_value("out_srcb", '0, out_srcb);
            check_value("out_imm", '0, out_imm);
            check_value("out_target", '0, out_target);
            accepted_prev = 1'b0;
            was_stalled   = 1'b0;
        end else begin
            // register holds a result after an accept or a stall
            check_value("in_ready", !(accepted_prev || was_stalled) || out_ready, in_ready);
            check_value("rs1_addr", in_instr[19:15], rs1_addr);
            check_value("rs2_addr", in_instr[24:20], rs2_addr);
            check_value("out_valid", accepted_prev || was_stalled, out_valid);
            if (was_stalled && out_bundle !== held_bundle) begin
                abort_run("outputs changed while out_ready was low");
            end
            if (accepted_prev) begin // one cycle latency
                check_value("out_pc", tdata[last_idx*n_field], out_pc);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("a result came out with no matching input");
                end
                idx = exp_q.pop_front();
                check_result(idx);
                n_checked++;
            end
            accepted_prev = in_valid && in_ready;
            if (accepted_prev) begin
                exp_q.push_back(n_accepted);
                last_idx = n_accepted;
                n_accepted++;
            end
            was_stalled = out_valid && !out_ready;
            held_bundle = out_bundle;
        end
    end

    initial begin : drive
        int vec;
        lfsr_state    = 32'h43f5eeb4;
        n_checked     = 0;
        n_accepted    = 0;
        last_idx      = 0;
        accepted_prev = 1'b0;
        was_stalled   = 1'b0;
        held_bundle   = '0;
        rst_n        <= 1'b0;
        in_valid      = 1'b0;
        out_ready     = 1'b0;
        in_pc         = '0;
        in_instr      = '0;
        rs1_data      = '0;
        rs2_data      = '0;
        $readmemh("verif/decode_testdata.txt", tdata);
        if ($isunknown(tdata[n_vec*n_field-1])) begin
            abort_run("test data file is missing or too short");
        end
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        vec = 0;
        while (n_checked < n_vec) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                vec++;
            end
            out_ready <= next_random_bit();
            if (vec < n_vec) begin
                in_valid <= next_random_bit();
                in_pc    <= tdata[vec*n_field];
                in_instr <= tdata[vec*n_field+1][31:0];
                rs1_data <= tdata[vec*n_field+2];
                rs2_data <= tdata[vec*n_field+3];
            end else begin
                in_valid <= 1'b0;
            end
        end
        repeat (3) @(posedge clk); // nothing extra may come out
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* verif/decode_testdata.txt */
// pc instr rs1_data rs2_data | srca srcb imm op_class alu_op mem_size mem_unsigned
// taken target illegal rd
1000 ffd30293 10 22 10 fffffffffffffffd fffffffffffffffd 1 0 3 0 0 0 0 5
1004 7ff43393 5 0 5 7ff 7ff 1 4 3 0 0 0 0 7
1008 42d55493 8000000000000000 0 8000000000000000 42d 42d 1 7 3 0 0 0 0 9
100c ff863583 2000 0 2000 fffffffffffffff8 fffffffffffffff8 7 0 3 0 0 0 0 b
1010 01074683 3000 0 3000 10 10 7 0 0 1 0 0 0 d
1014 fef83823 4000 1234 4000 fffffffffffffff0 fffffffffffffff0 8 0 3 0 0 0 0 10
1018 800018b7 55 0 0 ffffffff80001000 ffffffff80001000 2 0 3 0 0 0 0 11
2000 00208863 77 77 77 77 10 6 0 3 0 1 2010 0 10
2004 fe419ce3 5 5 5 5 fffffffffffffff8 6 0 3 0 0 1ffc 0 19
2008 0262c063 ffffffffffffffff 1 ffffffffffffffff 1 20 6 0 3 0 1 2028 0 0
200c 0262d063 ffffffffffffffff 1 ffffffffffffffff 1 20 6 0 3 0 0 202c 0 0
2010 0262e063 ffffffffffffffff 1 ffffffffffffffff 1 20 6 0 3 0 0 2030 0 0
2014 0262f063 ffffffffffffffff 1 ffffffffffffffff 1 20 6 0 3 0 1 2034 0 0
3000 801ff0ef 99 0 99 3004 fffffffffffff800 4 0 3 0 1 2800 0 1
3004 007100e7 4000 0 4000 3008 7 5 0 3 0 1 4006 0 1
3008 fffff197 5 0 3008 fffffffffffff000 fffffffffffff000 3 0 3 0 0 0 0 3
4000 0000007f 11 22 11 22 0 9 0 3 0 0 0 1 0
4004 022081b3 33 44 33 44 0 9 0 3 0 0 0 1 3
4008 0020a863 5 5 5 5 0 9 0 3 0 0 0 1 10
400c ff867583 2000 9 2000 9 0 9 0 3 0 0 0 1 b
4010 300110f3 66 77 66 77 0 9 0 3 0 0 0 1 1
4014 407302b3 100 1 100 1 0 0 1 3 0 0 0 0 5

/* vlog.f */
common/decode_pkg.sv
common/ctrl_if.sv
logic/opcode_decoder.sv
logic/imm_gen.sv
logic/branch_unit.sv
logic/operand_stage.sv
logic/decode_stage.sv
verif/decode_stage_tb.sv
